// File: common/icache_pkg.sv
package icache_pkg;

    // byte address and instruction word
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // line geometry: four words per line
    localparam int LINE_WORDS = 4;
    localparam int OFFSET_W   = 2;

    // byte select inside a word, ignored by the cache
    localparam int BYTE_OFF_W = 2;

    // everything above the line offset is tag, fully associative
    localparam int TAG_W = ADDR_W - OFFSET_W - BYTE_OFF_W;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [OFFSET_W-1:0] woff_t;

endpackage : icache_pkg

// File: common/wb_pkg.sv
package wb_pkg;

    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;

    // master to slave, read only so no we or sel
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic [WB_ADR_W-1:0] adr;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

endpackage : wb_pkg

// File: icache/icache_tag_store.sv
`timescale 1ns/1ps

module icache_tag_store
    import icache_pkg::*;
#(
    parameter int NUM_LANES = 4,
    localparam int LANE_W = $clog2(NUM_LANES)
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  tag_t              lookup_tag_i,
    input  logic              install_i,
    input  logic [LANE_W-1:0] install_lane_i,
    input  tag_t              install_tag_i,
    input  logic              flush_i,
    output logic              hit_o,
    output logic [LANE_W-1:0] hit_lane_o
);

    typedef struct packed {
        logic valid;
        tag_t tag;
    } entry_t;

    entry_t [NUM_LANES-1:0] entries_q;
    logic   [NUM_LANES-1:0] hit_vec;

    // only the valid bits are cleared, a stale tag is harmless
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                entries_q[i].valid <= 1'b0;
            end
        end else begin
            if (install_i) begin
                entries_q[install_lane_i].valid <= 1'b1;
                entries_q[install_lane_i].tag   <= install_tag_i;
            end
            // flush comes last so it wins over an install in the same cycle
            if (flush_i) begin
                for (int i = 0; i < NUM_LANES; i++) begin
                    entries_q[i].valid <= 1'b0;
                end
            end
        end
    end

    // parallel compare of every lane
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            hit_vec[i] = entries_q[i].valid && (entries_q[i].tag == lookup_tag_i);
        end
    end

    // hit_vec is one-hot or zero, so or-ing the indices encodes it
    always_comb begin
        hit_lane_o = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (hit_vec[i]) begin
                hit_lane_o = hit_lane_o | LANE_W'(i);
            end
        end
    end

    assign hit_o = |hit_vec;

endmodule : icache_tag_store

// File: icache/icache_data_store.sv
`timescale 1ns/1ps

module icache_data_store
    import icache_pkg::*;
#(
    parameter int NUM_LANES = 4,
    localparam int LANE_W = $clog2(NUM_LANES)
) (
    input  logic              clk_i,
    // refill side
    input  logic              wr_en_i,
    input  logic [LANE_W-1:0] wr_lane_i,
    input  woff_t             wr_off_i,
    input  word_t             wr_data_i,
    // lookup side
    input  logic [LANE_W-1:0] rd_lane_i,
    input  woff_t             rd_off_i,
    output word_t             rd_data_o
);

    // one line per lane, guarded by the valid bits in the tag store
    word_t lines_q [NUM_LANES][LINE_WORDS];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            lines_q[wr_lane_i][wr_off_i] <= wr_data_i;
        end
    end

    // combinational read, the control block registers it for the ack
    assign rd_data_o = lines_q[rd_lane_i][rd_off_i];

endmodule : icache_data_store

// File: icache/icache_refill.sv
`timescale 1ns/1ps

module icache_refill
    import icache_pkg::*, wb_pkg::*;
(
    input  logic    clk_i,
    input  logic    reset_i,
    input  logic    start_i,
    input  addr_t   line_addr_i,
    input  wb_rsp_t mem_rsp_i,
    output wb_req_t mem_req_o,
    output logic    wr_en_o,
    output woff_t   wr_off_o,
    output word_t   wr_data_o,
    output logic    done_o
);

    typedef enum logic {
        RF_IDLE,
        RF_READ
    } rf_state_e;

    rf_state_e state_q;
    tag_t      line_q;
    woff_t     cnt_q;
    logic      done_q;
    logic      word_ack;
    logic      last_ack;

    assign word_ack = (state_q == RF_READ) && mem_rsp_i.ack;
    assign last_ack = word_ack && (cnt_q == woff_t'(LINE_WORDS - 1));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= RF_IDLE;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= last_ack;
            case (state_q)
                RF_IDLE: begin
                    if (start_i) begin
                        state_q <= RF_READ;
                        cnt_q   <= '0;
                    end
                end
                RF_READ: begin
                    if (word_ack) begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                    // cyc and stb drop right after the last word
                    if (last_ack) begin
                        state_q <= RF_IDLE;
                    end
                end
                default: state_q <= RF_IDLE;
            endcase
        end
    end

    // line base is latched at start so the caller may move on
    always_ff @(posedge clk_i) begin
        if (state_q == RF_IDLE && start_i) begin
            line_q <= line_addr_i[ADDR_W-1 -: TAG_W];
        end
    end

    // stb stays up across words, the address steps after each ack
    assign mem_req_o.cyc = (state_q == RF_READ);
    assign mem_req_o.stb = (state_q == RF_READ);
    assign mem_req_o.adr = {line_q, cnt_q, {BYTE_OFF_W{1'b0}}};

    assign wr_en_o   = word_ack;
    assign wr_off_o  = cnt_q;
    assign wr_data_o = mem_rsp_i.dat;
    assign done_o    = done_q;

endmodule : icache_refill

// File: icache/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
    import icache_pkg::*, wb_pkg::*;
#(
    parameter int NUM_LANES = 4,
    localparam int LANE_W = $clog2(NUM_LANES)
) (
    input  logic              clk_i,
    input  logic              reset_i,
    // fetch side
    input  wb_req_t           cpu_req_i,
    output wb_rsp_t           cpu_rsp_o,
    input  logic              invalidate_i,
    // tag store
    output tag_t              lookup_tag_o,
    input  logic              hit_i,
    input  logic [LANE_W-1:0] hit_lane_i,
    output logic              install_o,
    output tag_t              install_tag_o,
    output logic              flush_o,
    // data store
    output logic [LANE_W-1:0] rd_lane_o,
    output woff_t             rd_off_o,
    input  word_t             rd_data_i,
    // refill engine
    output logic              refill_start_o,
    output addr_t             line_addr_o,
    output logic [LANE_W-1:0] victim_lane_o,
    input  logic              refill_done_i
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ACK,
        S_DROP,
        S_REFILL,
        S_INSTALL
    } state_e;

    state_e            state_q;
    state_e            state_d;
    logic [LANE_W-1:0] victim_q;
    tag_t              miss_tag_q;
    word_t             dat_q;
    logic              lookup_go;
    logic              fetch_idle;

    // S_DROP is the cycle after an ack: a held stb there counts as a new
    // lookup, so a slow master never sees two acks back to back
    assign fetch_idle = (state_q == S_IDLE) || (state_q == S_DROP);
    assign lookup_go  = fetch_idle && cpu_req_i.cyc && cpu_req_i.stb;

    // address split, byte bits are ignored
    assign lookup_tag_o = cpu_req_i.adr[ADDR_W-1 -: TAG_W];
    assign rd_off_o     = cpu_req_i.adr[BYTE_OFF_W +: OFFSET_W];
    assign rd_lane_o    = hit_lane_i;

    assign refill_start_o = lookup_go && !hit_i;
    assign line_addr_o    = {lookup_tag_o, {(ADDR_W - TAG_W){1'b0}}};
    assign victim_lane_o  = victim_q;

    assign install_o     = (state_q == S_INSTALL);
    assign install_tag_o = miss_tag_q;

    // flush only between fetches
    assign flush_o = fetch_idle && invalidate_i && !cpu_req_i.stb;

    assign cpu_rsp_o.ack = (state_q == S_ACK);
    assign cpu_rsp_o.dat = dat_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE, S_DROP: begin
                if (lookup_go) begin
                    state_d = hit_i ? S_ACK : S_REFILL;
                end else begin
                    state_d = S_IDLE;
                end
            end
            S_ACK:     state_d = S_DROP;
            S_REFILL: begin
                if (refill_done_i) begin
                    state_d = S_INSTALL;
                end
            end
            // back to idle, the held request then hits
            S_INSTALL: state_d = S_IDLE;
            default:   state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q  <= S_IDLE;
            victim_q <= '0;
        end else begin
            state_q <= state_d;
            // round robin, wraps since NUM_LANES is a power of two
            if (install_o) begin
                victim_q <= victim_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup_go && hit_i) begin
            dat_q <= rd_data_i;
        end
        if (refill_start_o) begin
            miss_tag_q <= lookup_tag_o;
        end
    end

endmodule : icache_ctrl

// File: icache/icache_top.sv
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*, wb_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic    clk_i,
    input  logic    reset_i,
    input  wb_req_t cpu_req_i,
    output wb_rsp_t cpu_rsp_o,
    input  logic    invalidate_i,
    output wb_req_t mem_req_o,
    input  wb_rsp_t mem_rsp_i
);

    localparam int LANE_W = $clog2(NUM_LANES);

    // lookup path
    tag_t              lookup_tag;
    logic              hit;
    logic [LANE_W-1:0] hit_lane;
    logic [LANE_W-1:0] rd_lane;
    woff_t             rd_off;
    word_t             rd_data;

    // miss path
    logic              refill_start;
    addr_t             line_addr;
    logic              refill_done;
    logic [LANE_W-1:0] victim_lane;
    logic              wr_en;
    woff_t             wr_off;
    word_t             wr_data;
    logic              install;
    tag_t              install_tag;
    logic              flush;

    icache_ctrl #(
        .NUM_LANES (NUM_LANES)
    ) i_ctrl (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .cpu_req_i      (cpu_req_i),
        .cpu_rsp_o      (cpu_rsp_o),
        .invalidate_i   (invalidate_i),
        .lookup_tag_o   (lookup_tag),
        .hit_i          (hit),
        .hit_lane_i     (hit_lane),
        .install_o      (install),
        .install_tag_o  (install_tag),
        .flush_o        (flush),
        .rd_lane_o      (rd_lane),
        .rd_off_o       (rd_off),
        .rd_data_i      (rd_data),
        .refill_start_o (refill_start),
        .line_addr_o    (line_addr),
        .victim_lane_o  (victim_lane),
        .refill_done_i  (refill_done)
    );

    icache_tag_store #(
        .NUM_LANES (NUM_LANES)
    ) i_tag (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .lookup_tag_i   (lookup_tag),
        .install_i      (install),
        .install_lane_i (victim_lane),
        .install_tag_i  (install_tag),
        .flush_i        (flush),
        .hit_o          (hit),
        .hit_lane_o     (hit_lane)
    );

    icache_data_store #(
        .NUM_LANES (NUM_LANES)
    ) i_data (
        .clk_i     (clk_i),
        .wr_en_i   (wr_en),
        .wr_lane_i (victim_lane),
        .wr_off_i  (wr_off),
        .wr_data_i (wr_data),
        .rd_lane_i (rd_lane),
        .rd_off_i  (rd_off),
        .rd_data_o (rd_data)
    );

    icache_refill i_refill (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .start_i     (refill_start),
        .line_addr_i (line_addr),
        .mem_rsp_i   (mem_rsp_i),
        .mem_req_o   (mem_req_o),
        .wr_en_o     (wr_en),
        .wr_off_o    (wr_off),
        .wr_data_o   (wr_data),
        .done_o      (refill_done)
    );

endmodule : icache_top

// File: dv/icache_asserts.sv
`timescale 1ns/1ps

module icache_asserts
    import wb_pkg::*;
(
    input logic    clk_i,
    input logic    reset_i,
    input wb_req_t cpu_req_i,
    input wb_rsp_t cpu_rsp_i,
    input wb_req_t mem_req_i,
    input wb_rsp_t mem_rsp_i
);

    int assert_failures = 0;

    cpu_stb_needs_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
        cpu_req_i.stb |-> cpu_req_i.cyc)
        else begin
            assert_failures++;
            $error("fetch side stb without cyc");
        end

    mem_stb_needs_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
        mem_req_i.stb |-> mem_req_i.cyc)
        else begin
            assert_failures++;
            $error("memory side stb without cyc");
        end

    // a slow master must never see a second ack straight away
    cpu_ack_single: assert property (@(posedge clk_i) disable iff (reset_i)
        cpu_rsp_i.ack |=> !cpu_rsp_i.ack)
        else begin
            assert_failures++;
            $error("fetch ack held for two cycles");
        end

    mem_adr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (mem_req_i.stb && !mem_rsp_i.ack) |=> $stable(mem_req_i.adr))
        else begin
            assert_failures++;
            $error("memory address changed before ack");
        end

endmodule : icache_asserts

bind icache_top icache_asserts i_asserts (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .cpu_req_i (cpu_req_i),
    .cpu_rsp_i (cpu_rsp_o),
    .mem_req_i (mem_req_o),
    .mem_rsp_i (mem_rsp_i)
);

// File: dv/icache_tb.sv
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*, wb_pkg::*;
();

    localparam int  NUM_LANES      = 4;
    localparam real CLK_PERIOD     = 4.0;
    localparam int  RESET_CYCLES   = 16;
    // four words at up to five cycles each, then done, install, lookup and ack
    localparam int  MISS_CYCLES    = 30;
    localparam int  FETCH_LIMIT    = 2 * MISS_CYCLES;
    localparam int  RAND_FETCHES   = 40;
    localparam int  TOTAL_FETCHES  = 27 + RAND_FETCHES;
    localparam int  TIMEOUT_CYCLES = RESET_CYCLES + TOTAL_FETCHES * MISS_CYCLES + 200;
    localparam word_t MEM_KEY      = 32'h5A3C_96E1;

    logic    clk_i;
    logic    reset_i;
    wb_req_t cpu_req;
    wb_rsp_t cpu_rsp;
    logic    invalidate;
    wb_req_t mem_req;
    wb_rsp_t mem_rsp;

    int      errors;
    int      mem_reads;
    int      mem_wait;
    logic    mem_busy;
    addr_t   mem_addrs[$];

    icache_top #(
        .NUM_LANES (NUM_LANES)
    ) i_dut (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .cpu_req_i    (cpu_req),
        .cpu_rsp_o    (cpu_rsp),
        .invalidate_i (invalidate),
        .mem_req_o    (mem_req),
        .mem_rsp_i    (mem_rsp)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles before the tests finished", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // memory content is the word address scrambled with a constant
    function automatic word_t mem_word(input addr_t adr);
        return {adr[ADDR_W-1:2], 2'b00} ^ MEM_KEY;
    endfunction

    // memory slave with 0 to 3 wait states per read
    always @(negedge clk_i) begin
        if (reset_i) begin
            mem_rsp  = '0;
            mem_busy = 1'b0;
        end else if (mem_rsp.ack) begin
            mem_rsp.ack = 1'b0;
            mem_busy    = 1'b0;
        end else if (mem_req.cyc && mem_req.stb) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = $urandom % 4;
            end
            if (mem_wait == 0) begin
                mem_rsp.ack = 1'b1;
                mem_rsp.dat = mem_word(mem_req.adr);
                mem_reads++;
                mem_addrs.push_back(mem_req.adr);
            end else begin
                mem_wait--;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic idle_cycle();
        cpu_req.cyc = 1'b0;
        cpu_req.stb = 1'b0;
        @(negedge clk_i);
    endtask

    // one Wishbone classic read on the fetch side
    task automatic fetch(input addr_t adr, output word_t dat, output int cycles);
        cpu_req.cyc = 1'b1;
        cpu_req.stb = 1'b1;
        cpu_req.adr = adr;
        cycles = 0;
        dat = '0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!cpu_rsp.ack && cycles < FETCH_LIMIT);
        if (cpu_rsp.ack) begin
            dat = cpu_rsp.dat;
        end else begin
            errors++;
            $display("no fetch acknowledge for address %h within %0d cycles", adr, FETCH_LIMIT);
        end
        cpu_req.cyc = 1'b0;
        cpu_req.stb = 1'b0;
    endtask

    // a negative read count skips the memory traffic check
    task automatic fetch_check(input addr_t adr, input int exp_reads);
        int    reads_before;
        word_t dat;
        int    cycles;
        reads_before = mem_reads;
        fetch(adr, dat, cycles);
        check_value("cpu_rsp_o.dat", dat, mem_word(adr));
        if (exp_reads >= 0) begin
            check_value("memory read count", mem_reads - reads_before, exp_reads);
        end
    endtask

    task automatic flush_cache();
        idle_cycle();
        invalidate = 1'b1;
        @(negedge clk_i);
        invalidate = 1'b0;
    endtask

    task automatic cold_line_test();
        addr_t base;
        base = 32'h0000_1230;
        mem_addrs.delete();
        fetch_check(base + 32'h8, 4);
        if (mem_addrs.size() == LINE_WORDS) begin
            for (int i = 0; i < LINE_WORDS; i++) begin
                check_value("mem_req_o.adr", mem_addrs[i], base + addr_t'(4 * i));
            end
        end
    endtask

    task automatic same_line_test();
        addr_t base;
        word_t dat;
        int    cycles;
        int    reads_before;
        base = 32'h0000_1230;
        for (int i = 0; i < LINE_WORDS; i++) begin
            if (i != 2) begin
                idle_cycle();
                reads_before = mem_reads;
                // low address bits vary too, the cache ignores them
                fetch(base + addr_t'(4 * i + i), dat, cycles);
                check_value("cpu_rsp_o.dat", dat, mem_word(base + addr_t'(4 * i)));
                check_value("memory read count", mem_reads - reads_before, 0);
                check_value("hit latency in cycles", cycles, 1);
            end
        end
    endtask

    task automatic eviction_test();
        addr_t lines [NUM_LANES + 1];
        flush_cache();
        for (int i = 0; i <= NUM_LANES; i++) begin
            lines[i] = 32'h0002_0000 + addr_t'(i * 32'h140);
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            fetch_check(lines[i], 4);
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            fetch_check(lines[i] + 32'h4, 0);
        end
        // the oldest line goes first
        fetch_check(lines[NUM_LANES], 4);
        fetch_check(lines[1], 0);
        fetch_check(lines[0] + 32'hC, 4);
    endtask

    task automatic invalidate_test();
        addr_t lines [NUM_LANES];
        for (int i = 0; i < NUM_LANES; i++) begin
            lines[i] = 32'h0003_0000 + addr_t'(i * 32'h10);
            fetch_check(lines[i], 4);
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            fetch_check(lines[i] + 32'h4, 0);
        end
        flush_cache();
        for (int i = 0; i < NUM_LANES; i++) begin
            fetch_check(lines[i] + 32'h8, 4);
        end
    endtask

    task automatic random_fetch_test();
        addr_t adr;
        for (int n = 0; n < RAND_FETCHES; n++) begin
            // sixteen lines over four lanes gives a mix of hits and misses
            adr = 32'h0004_0000 + addr_t'($urandom % 256);
            fetch_check(adr, -1);
        end
    endtask

    initial begin
        void'($urandom(93));
        errors     = 0;
        mem_reads  = 0;
        mem_wait   = 0;
        mem_busy   = 1'b0;
        reset_i    = 1'b1;
        cpu_req    = '0;
        invalidate = 1'b0;
        mem_rsp    = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_i = 1'b0;
        cold_line_test();
        same_line_test();
        eviction_test();
        invalidate_test();
        random_fetch_test();
        idle_cycle();
        idle_cycle();
        errors += i_dut.i_asserts.assert_failures;
        $display("tests done with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : icache_tb

// File: project.f
common/icache_pkg.sv
common/wb_pkg.sv
icache/icache_tag_store.sv
icache/icache_data_store.sv
icache/icache_refill.sv
icache/icache_ctrl.sv
icache/icache_top.sv
dv/icache_asserts.sv
dv/icache_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := icache_tb
FILELIST   := project.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := TEST OK

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
